//--- common/p2p_defines.svh
`ifndef P2P_DEFINES_SVH
`define P2P_DEFINES_SVH

// lane and stream geometry
`define P2P_NUM_LANES     2
`define P2P_DATA_W        64   // tkeep is one bit per byte of this
`define P2P_ID_W          4
`define P2P_DEST_W        4
`define P2P_USER_W        16

// register byte offsets
`define P2P_REG_PAUSE     8'h00   // read-write mask with one bit per lane
`define P2P_REG_TS_LATCH  8'h04   // write-only snapshot trigger
`define P2P_REG_TS_UPPER  8'h08   // read-only snapshot bits 63:32
`define P2P_REG_TS_LOWER  8'h0C   // read-only snapshot bits 31:0
`define P2P_REG_PKT_BASE  8'h10   // read-only count of lane i at base + 4*i

`endif

//--- common/p2p_pkg.sv
`include "p2p_defines.svh"

package p2p_pkg;

   // one stream beat without its handshake
   typedef struct packed {
      logic [`P2P_DATA_W-1:0]   tdata;
      logic [`P2P_DATA_W/8-1:0] tkeep;
      logic                     tlast;
      logic [`P2P_ID_W-1:0]     tid;
      logic [`P2P_DEST_W-1:0]   tdest;
      logic [`P2P_USER_W-1:0]   tuser;
   } axis_beat_t;

   typedef logic [7:0]  reg_addr_t;    // register byte address
   typedef logic [31:0] reg_data_t;

   typedef logic [31:0] pkt_cnt_t;     // wraps at 2^32
   typedef logic [63:0] timestamp_t;

endpackage

//--- common/axis_lane_if.sv
`timescale 1ns/1ps

interface axis_lane_if #(
   parameter type beat_t = p2p_pkg::axis_beat_t
);

   logic  valid;
   logic  ready;
   beat_t beat;    // payload qualified by valid

   // beat moves on an edge with valid and ready both high
   modport tx (
      output valid,
      output beat,
      input  ready
   );

   modport rx (
      input  valid,
      input  beat,
      output ready
   );

endinterface

//--- common/p2p_reg_if.sv
`timescale 1ns/1ps
`include "p2p_defines.svh"

interface p2p_reg_if;

   import p2p_pkg::*;

   logic [`P2P_NUM_LANES-1:0] pause;           // from register block
   logic                      ts_latch_evt;    // one-cycle pulse
   pkt_cnt_t                  live_cnt [`P2P_NUM_LANES];   // one entry per lane
   timestamp_t                snap_ts;
   pkt_cnt_t                  snap_cnt [`P2P_NUM_LANES];

   modport ctrl (
      output pause,
      output ts_latch_evt,
      input  snap_ts,
      input  snap_cnt
   );

   // the top picks out bit and entry i for lane i
   modport lane (
      input  pause,
      output live_cnt
   );

   modport collect (
      input  ts_latch_evt,
      input  live_cnt,
      output snap_ts,
      output snap_cnt
   );

endinterface

//--- regs/p2p_reg_blk.sv
`timescale 1ns/1ps
`include "p2p_defines.svh"

module p2p_reg_blk (
   input  logic                core_clk,
   input  logic                reset,

   input  logic                wr_valid,
   output logic                wr_ready,
   input  p2p_pkg::reg_addr_t  wr_addr,
   input  p2p_pkg::reg_data_t  wr_data,
   output logic                wr_done,

   input  logic                rd_valid,
   output logic                rd_ready,
   input  p2p_pkg::reg_addr_t  rd_addr,
   output logic                rd_data_valid,
   output p2p_pkg::reg_data_t  rd_data,

   p2p_reg_if.ctrl             reg_if
);

   import p2p_pkg::*;

   logic                      wr_accept;
   logic                      rd_accept;
   logic                      wr_done_q;
   logic                      ts_latch_q;
   logic                      rd_valid_q;
   logic [`P2P_NUM_LANES-1:0] pause_q;
   reg_data_t                 rd_mux;
   reg_data_t                 rd_data_q;

   assign wr_ready  = ~wr_done_q;    // one write in flight at a time
   assign rd_ready  = 1'b1;          // one-cycle read latency that never stalls
   assign wr_accept = wr_valid & wr_ready;
   assign rd_accept = rd_valid & rd_ready;

   // write side
   always_ff @(posedge core_clk) begin
      if (reset) begin
         wr_done_q  <= 1'b0;
         ts_latch_q <= 1'b0;
         pause_q    <= '0;
      end else begin
         wr_done_q  <= wr_accept;
         ts_latch_q <= wr_accept && (wr_addr == `P2P_REG_TS_LATCH);
         if (wr_accept && (wr_addr == `P2P_REG_PAUSE)) begin
            pause_q <= wr_data[`P2P_NUM_LANES-1:0];    // upper bits dropped
         end
      end
   end

   // unmapped offsets and TS_LATCH read as zero
   always_comb begin
      rd_mux = '0;
      case (rd_addr)
         `P2P_REG_PAUSE:    rd_mux = reg_data_t'(pause_q);
         `P2P_REG_TS_UPPER: rd_mux = reg_if.snap_ts[63:32];
         `P2P_REG_TS_LOWER: rd_mux = reg_if.snap_ts[31:0];
         default: begin
            for (int i = 0; i < `P2P_NUM_LANES; i++) begin
               if (rd_addr == reg_addr_t'(`P2P_REG_PKT_BASE + 4 * i)) begin
                  rd_mux = reg_if.snap_cnt[i];
               end
            end
         end
      endcase
   end

   always_ff @(posedge core_clk) begin
      if (reset) begin
         rd_valid_q <= 1'b0;
      end else begin
         rd_valid_q <= rd_accept;
      end
   end

   always_ff @(posedge core_clk) begin
      if (rd_accept) begin
         rd_data_q <= rd_mux;    // held until the next read
      end
   end

   assign wr_done             = wr_done_q;
   assign rd_data_valid       = rd_valid_q;
   assign rd_data             = rd_data_q;
   assign reg_if.pause        = pause_q;
   assign reg_if.ts_latch_evt = ts_latch_q;

   a_wr_done_pulse: assert property (@(posedge core_clk) disable iff (reset)
      wr_done |=> !wr_done);

   a_latch_pulse: assert property (@(posedge core_clk) disable iff (reset)
      reg_if.ts_latch_evt |=> !reg_if.ts_latch_evt);

   a_rd_follows_req: assert property (@(posedge core_clk) disable iff (reset)
      rd_data_valid |-> $past(rd_valid && rd_ready));

endmodule

//--- logic/p2p_lane.sv
`timescale 1ns/1ps

module p2p_lane #(
   parameter type beat_t = p2p_pkg::axis_beat_t
) (
   input  logic              core_clk,
   input  logic              reset,

   axis_lane_if.rx           rx,
   axis_lane_if.tx           tx,

   input  logic              pause,
   output p2p_pkg::pkt_cnt_t live_cnt
);

   import p2p_pkg::*;

   beat_t    beat;
   logic     xfer;
   pkt_cnt_t cnt_q;

   // zero-latency data path with nothing buffered
   assign beat    = rx.beat;
   assign tx.beat = beat;

   // pause closes the lane in both directions
   assign tx.valid = rx.valid & ~pause;
   assign rx.ready = tx.ready & ~pause;

   assign xfer = tx.valid & tx.ready;

   // one count per packet, taken on its last beat
   always_ff @(posedge core_clk) begin
      if (reset) begin
         cnt_q <= '0;
      end else if (xfer && beat.tlast) begin
         cnt_q <= cnt_q + 1'b1;    // wraps naturally
      end
   end

   assign live_cnt = cnt_q;

   a_pause_blocks: assert property (@(posedge core_clk) disable iff (reset)
      pause |-> !tx.valid && !rx.ready);

endmodule

//--- logic/p2p_status_collect.sv
`timescale 1ns/1ps
`include "p2p_defines.svh"

module p2p_status_collect (
   input  logic                core_clk,
   input  logic                reset,
   input  p2p_pkg::timestamp_t timestamp,
   p2p_reg_if.collect          reg_if
);

   import p2p_pkg::*;

   timestamp_t snap_ts_q;
   pkt_cnt_t   snap_cnt_q [`P2P_NUM_LANES];

   // timestamp and every lane count captured on the same edge
   always_ff @(posedge core_clk) begin
      if (reset) begin
         snap_ts_q  <= '0;
         snap_cnt_q <= '{default: '0};
      end else if (reg_if.ts_latch_evt) begin
         snap_ts_q  <= timestamp;
         snap_cnt_q <= reg_if.live_cnt;
      end
   end

   assign reg_if.snap_ts  = snap_ts_q;
   assign reg_if.snap_cnt = snap_cnt_q;

   for (genvar g = 0; g < `P2P_NUM_LANES; g++) begin : g_chk
      a_snap_hold: assert property (@(posedge core_clk) disable iff (reset)
         !$past(reg_if.ts_latch_evt) |-> $stable(snap_ts_q) && $stable(snap_cnt_q[g]));
   end

endmodule

//--- logic/p2p_shell.sv
`timescale 1ns/1ps
`include "p2p_defines.svh"

module p2p_shell (
   input  logic                                         core_clk,
   input  logic                                         reset,

   input  logic [`P2P_NUM_LANES-1:0]                    in_tvalid,
   output logic [`P2P_NUM_LANES-1:0]                    in_tready,
   input  logic [`P2P_NUM_LANES-1:0][`P2P_DATA_W-1:0]   in_tdata,
   input  logic [`P2P_NUM_LANES-1:0][`P2P_DATA_W/8-1:0] in_tkeep,
   input  logic [`P2P_NUM_LANES-1:0]                    in_tlast,
   input  logic [`P2P_NUM_LANES-1:0][`P2P_ID_W-1:0]     in_tid,
   input  logic [`P2P_NUM_LANES-1:0][`P2P_DEST_W-1:0]   in_tdest,
   input  logic [`P2P_NUM_LANES-1:0][`P2P_USER_W-1:0]   in_tuser,

   output logic [`P2P_NUM_LANES-1:0]                    out_tvalid,
   input  logic [`P2P_NUM_LANES-1:0]                    out_tready,
   output logic [`P2P_NUM_LANES-1:0][`P2P_DATA_W-1:0]   out_tdata,
   output logic [`P2P_NUM_LANES-1:0][`P2P_DATA_W/8-1:0] out_tkeep,
   output logic [`P2P_NUM_LANES-1:0]                    out_tlast,
   output logic [`P2P_NUM_LANES-1:0][`P2P_ID_W-1:0]     out_tid,
   output logic [`P2P_NUM_LANES-1:0][`P2P_DEST_W-1:0]   out_tdest,
   output logic [`P2P_NUM_LANES-1:0][`P2P_USER_W-1:0]   out_tuser,

   input  p2p_pkg::timestamp_t                          timestamp,

   input  logic                                         wr_valid,
   output logic                                         wr_ready,
   input  p2p_pkg::reg_addr_t                           wr_addr,
   input  p2p_pkg::reg_data_t                           wr_data,
   output logic                                         wr_done,

   input  logic                                         rd_valid,
   output logic                                         rd_ready,
   input  p2p_pkg::reg_addr_t                           rd_addr,
   output logic                                         rd_data_valid,
   output p2p_pkg::reg_data_t                           rd_data
);

   import p2p_pkg::*;

   p2p_reg_if reg_if ();

   p2p_reg_blk u_reg_blk (
      .core_clk      (core_clk),
      .reset         (reset),
      .wr_valid      (wr_valid),
      .wr_ready      (wr_ready),
      .wr_addr       (wr_addr),
      .wr_data       (wr_data),
      .wr_done       (wr_done),
      .rd_valid      (rd_valid),
      .rd_ready      (rd_ready),
      .rd_addr       (rd_addr),
      .rd_data_valid (rd_data_valid),
      .rd_data       (rd_data),
      .reg_if        (reg_if.ctrl)
   );

   p2p_status_collect u_collect (
      .core_clk  (core_clk),
      .reset     (reset),
      .timestamp (timestamp),
      .reg_if    (reg_if.collect)
   );

   for (genvar i = 0; i < `P2P_NUM_LANES; i++) begin : g_lane
      axis_lane_if #(.beat_t(axis_beat_t)) in_if ();    // from the switch port
      axis_lane_if #(.beat_t(axis_beat_t)) out_if ();   // toward the switch port

      assign in_if.valid = in_tvalid[i];
      assign in_if.beat  = '{tdata: in_tdata[i], tkeep: in_tkeep[i], tlast: in_tlast[i],
                             tid: in_tid[i], tdest: in_tdest[i], tuser: in_tuser[i]};
      assign in_tready[i] = in_if.ready;

      assign out_tvalid[i] = out_if.valid;
      assign out_if.ready  = out_tready[i];
      assign out_tdata[i]  = out_if.beat.tdata;
      assign out_tkeep[i]  = out_if.beat.tkeep;
      assign out_tlast[i]  = out_if.beat.tlast;
      assign out_tid[i]    = out_if.beat.tid;
      assign out_tdest[i]  = out_if.beat.tdest;
      assign out_tuser[i]  = out_if.beat.tuser;

      p2p_lane #(.beat_t(axis_beat_t)) u_lane (
         .core_clk (core_clk),
         .reset    (reset),
         .rx       (in_if.rx),
         .tx       (out_if.tx),
         .pause    (reg_if.pause[i]),
         .live_cnt (reg_if.live_cnt[i])
      );
   end

endmodule

//--- dv/p2p_shell_tb_checks.svh
task automatic report_fail(input string line);
   $display("%s", line);
   $display("Simulation FAILED");
   $fatal(1, "%s", line);
endtask

task automatic check_beat(input string name, input p2p_pkg::axis_beat_t exp,
                          input p2p_pkg::axis_beat_t act);
   if (act !== exp)
      report_fail($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
endtask

task automatic check_reg(input string name, input p2p_pkg::reg_data_t exp,
                         input p2p_pkg::reg_data_t act);
   if (act !== exp)
      report_fail($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
   if (act !== exp)
      report_fail($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
endtask

task automatic reg_write(input p2p_pkg::reg_addr_t addr, input p2p_pkg::reg_data_t data);
   int waited;
   @(posedge core_clk);
   #1;
   wr_valid = 1'b1;
   wr_addr  = addr;
   wr_data  = data;
   waited   = 0;
   @(negedge core_clk);
   while (!wr_ready) begin
      waited++;
      if (waited > WAIT_LIMIT)
         report_fail("register write was never accepted");
      @(negedge core_clk);
   end
   @(posedge core_clk);    // accepting edge
   #1;
   wr_valid = 1'b0;
   if (addr == `P2P_REG_PAUSE)
      pause_m = data[N-1:0];    // mask keeps lane bits only
   waited = 0;
   @(negedge core_clk);
   while (!wr_done) begin
      waited++;
      if (waited > WAIT_LIMIT)
         report_fail("write response never arrived");
      @(negedge core_clk);
   end
   check_bit("wr_ready while write pending", 1'b0, wr_ready);
   @(posedge core_clk);    // snapshot edge for a latch write
   #1;
endtask

task automatic reg_read(input p2p_pkg::reg_addr_t addr, output p2p_pkg::reg_data_t data);
   int waited;
   @(posedge core_clk);
   #1;
   rd_valid = 1'b1;
   rd_addr  = addr;
   waited   = 0;
   @(negedge core_clk);
   while (!rd_ready) begin
      waited++;
      if (waited > WAIT_LIMIT)
         report_fail("register read was never accepted");
      @(negedge core_clk);
   end
   @(posedge core_clk);
   #1;
   rd_valid = 1'b0;
   waited   = 0;
   @(negedge core_clk);
   while (!rd_data_valid) begin
      waited++;
      if (waited > WAIT_LIMIT)
         report_fail("read data never arrived");
      @(negedge core_clk);
   end
   data = rd_data;
endtask

//--- dv/p2p_shell_tb.sv
`timescale 1ns/1ps
`include "p2p_defines.svh"

module p2p_shell_tb;

   import p2p_pkg::*;

   localparam int N          = `P2P_NUM_LANES;
   localparam int WAIT_LIMIT = 40;

   logic core_clk;
   logic reset;
   logic [N-1:0] in_tvalid, in_tready, in_tlast, out_tvalid, out_tready, out_tlast;
   logic [N-1:0][`P2P_DATA_W-1:0]   in_tdata, out_tdata;
   logic [N-1:0][`P2P_DATA_W/8-1:0] in_tkeep, out_tkeep;
   logic [N-1:0][`P2P_ID_W-1:0]     in_tid, out_tid;
   logic [N-1:0][`P2P_DEST_W-1:0]   in_tdest, out_tdest;
   logic [N-1:0][`P2P_USER_W-1:0]   in_tuser, out_tuser;
   timestamp_t timestamp;
   logic       wr_valid, wr_ready, wr_done, rd_valid, rd_ready, rd_data_valid;
   reg_addr_t  wr_addr, rd_addr;
   reg_data_t  wr_data, rd_data;

   logic [N-1:0] pause_m;    // modeled pause mask
   pkt_cnt_t     cnt_m [N];  // tlast beats seen crossing each lane
   pkt_cnt_t     snap_cnt_m [N];
   timestamp_t   snap_ts_m;
   timestamp_t   ts_val;
   reg_data_t    wr_val;
   bit           traffic_on;

   p2p_shell u_dut (.*);

   `include "p2p_shell_tb_checks.svh"

   initial core_clk = 1'b0;
   always #10 core_clk = ~core_clk;

   function automatic axis_beat_t exp_out_beat(input axis_beat_t in_b);
      return in_b;    // lanes pass beats untouched
   endfunction

   function automatic logic exp_gated(input logic v, input logic paused);
      return v & ~paused;
   endfunction

   function automatic reg_data_t exp_reg(input reg_addr_t addr);
      reg_data_t val;
      val = '0;
      if (addr == `P2P_REG_PAUSE)
         val = reg_data_t'(pause_m);
      else if (addr == `P2P_REG_TS_UPPER)
         val = snap_ts_m[63:32];
      else if (addr == `P2P_REG_TS_LOWER)
         val = snap_ts_m[31:0];
      for (int i = 0; i < N; i++)
         if (addr == reg_addr_t'(`P2P_REG_PKT_BASE + 4 * i))
            val = snap_cnt_m[i];
      return val;
   endfunction

   task automatic read_expect(input string name, input reg_addr_t addr, input reg_data_t exp);
      reg_data_t got;
      reg_read(addr, got);
      check_reg(name, exp, got);
   endtask

   // random traffic where valid never looks at ready
   always @(posedge core_clk) begin
      #1;
      for (int i = 0; i < N; i++) begin
         out_tready[i] = ($urandom_range(0, 3) != 0);
         in_tvalid[i]  = traffic_on && ($urandom_range(0, 3) != 0);
         in_tdata[i]   = {$urandom, $urandom};
         in_tkeep[i]   = $urandom;
         in_tlast[i]   = $urandom_range(0, 1);
         in_tid[i]     = $urandom;
         in_tdest[i]   = $urandom;
         in_tuser[i]   = $urandom;
      end
   end

   // outputs are settled by the falling edge
   always @(negedge core_clk) begin : compare_outputs
      axis_beat_t in_b;
      axis_beat_t out_b;
      if (!reset) begin
         for (int i = 0; i < N; i++) begin
            in_b  = '{in_tdata[i], in_tkeep[i], in_tlast[i], in_tid[i], in_tdest[i], in_tuser[i]};
            out_b = '{out_tdata[i], out_tkeep[i], out_tlast[i], out_tid[i], out_tdest[i],
                      out_tuser[i]};
            check_beat($sformatf("lane %0d beat", i), exp_out_beat(in_b), out_b);
            check_bit($sformatf("lane %0d out_tvalid", i),
                      exp_gated(in_tvalid[i], pause_m[i]), out_tvalid[i]);
            check_bit($sformatf("lane %0d in_tready", i),
                      exp_gated(out_tready[i], pause_m[i]), in_tready[i]);
            if (exp_gated(in_tvalid[i], pause_m[i]) && exp_gated(out_tready[i], pause_m[i])
                && in_tlast[i])
               cnt_m[i] = cnt_m[i] + 1;    // packet ends on the coming edge
         end
      end
   end

   initial begin
      void'($urandom(32'h50693d6c));
      reset      = 1'b1;
      traffic_on = 1'b0;
      pause_m    = '0;
      cnt_m      = '{default: '0};
      snap_cnt_m = '{default: '0};
      snap_ts_m  = '0;
      in_tvalid  = '0;
      in_tdata   = '0;
      in_tkeep   = '0;
      in_tlast   = '0;
      in_tid     = '0;
      in_tdest   = '0;
      in_tuser   = '0;
      out_tready = '0;
      timestamp  = {$urandom, $urandom};
      wr_valid   = 1'b0;
      wr_addr    = '0;
      wr_data    = '0;
      rd_valid   = 1'b0;
      rd_addr    = '0;
      repeat (16) @(posedge core_clk);
      #1;
      reset = 1'b0;

      @(negedge core_clk);
      check_bit("wr_ready after reset", 1'b1, wr_ready);
      check_bit("rd_ready after reset", 1'b1, rd_ready);
      read_expect("reset pause", `P2P_REG_PAUSE, '0);
      read_expect("reset ts upper", `P2P_REG_TS_UPPER, '0);
      read_expect("reset ts lower", `P2P_REG_TS_LOWER, '0);
      for (int i = 0; i < N; i++)
         read_expect($sformatf("reset pkt %0d", i), `P2P_REG_PKT_BASE + 4 * i, '0);

      traffic_on = 1'b1;    // open lanes while the compare process watches pass-through
      repeat (60) @(posedge core_clk);

      wr_val = $urandom;
      reg_write(`P2P_REG_PAUSE, wr_val);
      read_expect("pause readback", `P2P_REG_PAUSE, exp_reg(`P2P_REG_PAUSE));
      reg_write(`P2P_REG_PAUSE, 32'h1);    // lane 0 closed and lane 1 open
      repeat (30) @(posedge core_clk);
      read_expect("unknown address", 8'h40, '0);
      read_expect("latch register read", `P2P_REG_TS_LATCH, '0);

      for (int round = 0; round < 4; round++) begin
         repeat (4) begin
            reg_write(`P2P_REG_PAUSE, $urandom);
            repeat ($urandom_range(10, 30)) @(posedge core_clk);
         end
         traffic_on = 1'b0;
         repeat (3) @(posedge core_clk);
         #1;
         ts_val    = {$urandom, $urandom};
         timestamp = ts_val;
         reg_write(`P2P_REG_TS_LATCH, '0);
         timestamp  = {$urandom, $urandom};    // held value must stay in the snapshot
         snap_ts_m  = ts_val;
         snap_cnt_m = cnt_m;
         reg_write(`P2P_REG_PAUSE, '0);    // both lanes open so live counts move on
         read_expect("snapshot ts upper", `P2P_REG_TS_UPPER, exp_reg(`P2P_REG_TS_UPPER));
         read_expect("snapshot ts lower", `P2P_REG_TS_LOWER, exp_reg(`P2P_REG_TS_LOWER));
         for (int i = 0; i < N; i++)
            read_expect($sformatf("snapshot pkt %0d", i), `P2P_REG_PKT_BASE + 4 * i,
                        exp_reg(`P2P_REG_PKT_BASE + 4 * i));
         traffic_on = 1'b1;
         repeat (40) @(posedge core_clk);
         for (int i = 0; i < N; i++)
            read_expect($sformatf("held pkt %0d", i), `P2P_REG_PKT_BASE + 4 * i,
                        exp_reg(`P2P_REG_PKT_BASE + 4 * i));
      end

      $display("Simulation PASSED");
      $finish;
   end

endmodule

//--- p2p_shell.f
+incdir+common
+incdir+dv
common/p2p_pkg.sv
common/axis_lane_if.sv
common/p2p_reg_if.sv
regs/p2p_reg_blk.sv
logic/p2p_lane.sv
logic/p2p_status_collect.sv
logic/p2p_shell.sv
dv/p2p_shell_tb.sv
